// File: flist.f
+incdir+.
eeprom_pkg.sv
eeprom_wb_slave.sv
eeprom_sequencer.sv
eeprom_bit_engine.sv
eeprom_ctrl_top.sv
eeprom_ctrl_sva.sv
tb_eeprom_model.sv
tb_eeprom_checker.sv
tb_eeprom_ctrl.sv

// File: Makefile
TOP = tb_eeprom_ctrl

.PHONY: lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_eeprom_ctrl.sv
`timescale 1ns/10ps

module tb_eeprom_ctrl;

    logic              CLK;
    logic              RESET;
    logic              cyc;
    logic              stb;
    logic              we;
    eeprom_pkg::addr_t adr;
    eeprom_pkg::byte_t dat_w;
    eeprom_pkg::byte_t dat_r;
    logic              ack;
    logic              err;
    logic              scl;
    logic              sda_pull;
    logic              sda_pad;
    logic              model_pull;
    logic              nack_en;
    int                start_cnt;
    int                restart_cnt;
    int                stop_cnt;
    int                chk_errors;
    int                tmo_errors;
    int                seed;
    int                r;
    int                kind;
    logic              aborted;
    eeprom_pkg::addr_t pool [0:15];
    eeprom_pkg::addr_t a;
    eeprom_pkg::byte_t d;

    // open drain pad with pull-up
    assign sda_pad = !(sda_pull || model_pull);

    always #4 CLK = !CLK;

    eeprom_ctrl_top uut
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .dat_r    (dat_r),
        .ack      (ack),
        .err      (err),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda_pad)
    );

    tb_eeprom_model model
    (
        .scl         (scl),
        .sda         (sda_pad),
        .nack_en     (nack_en),
        .pull        (model_pull),
        .start_cnt   (start_cnt),
        .restart_cnt (restart_cnt),
        .stop_cnt    (stop_cnt)
    );

    tb_eeprom_checker chk
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .dat_r       (dat_r),
        .ack         (ack),
        .err         (err),
        .scl         (scl),
        .sda_pull    (sda_pull),
        .sda_pad     (sda_pad),
        .nack_en     (nack_en),
        .start_cnt   (start_cnt),
        .restart_cnt (restart_cnt),
        .stop_cnt    (stop_cnt),
        .errors      (chk_errors)
    );

    task run_transfer(input logic w, input eeprom_pkg::addr_t ta, input eeprom_pkg::byte_t td,
                      input logic refuse);
        int cycles;
        cycles = 0;
        @(posedge CLK);
        #1;
        cyc     = 1'b1;
        stb     = 1'b1;
        we      = w;
        adr     = ta;
        dat_w   = td;
        nack_en = refuse;
        while (!(ack || err) && cycles < 5000)
        begin
            @(negedge CLK);
            cycles++;
        end
        if (!(ack || err))
        begin
            $display("Error at %0t: no ack or err within %0d cycles", $time, cycles);
            tmo_errors++;
            aborted = 1'b1;
        end
        @(posedge CLK);
        #1;
        cyc     = 1'b0;
        stb     = 1'b0;
        we      = 1'b0;
        nack_en = 1'b0;
    endtask

    initial
    begin
        CLK        = 1'b0;
        RESET      = 1'b1;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        nack_en    = 1'b0;
        tmo_errors = 0;
        aborted    = 1'b0;
        seed       = 12650;
        repeat (3) @(posedge CLK);
        #1;
        RESET = 1'b0;
        for (int i = 0; i < 16; i++)
        begin
            r       = $random(seed);
            pool[i] = r[10:0];
        end
        for (int n = 0; n < 200 && !aborted; n++)
        begin
            r    = $random(seed);
            kind = $unsigned(r) % 3;
            r    = $random(seed);
            a    = pool[r[3:0]];
            d    = r[15:8];
            if (kind == 0)
                run_transfer(1'b1, a, d, 1'b0);
            else if (kind == 1)
                run_transfer(1'b0, a, d, 1'b0);
            else
            begin
                run_transfer(r[16], a, d, 1'b1);
                if (!aborted)
                    run_transfer(1'b0, a, d, 1'b0);   // location must be untouched
            end
        end
        repeat (10) @(posedge CLK);
        $display("Error counts: %0d check, %0d timeout", chk_errors, tmo_errors);
        if (chk_errors == 0 && tmo_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: tb_eeprom_checker.sv
`timescale 1ns/10ps

module tb_eeprom_checker
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  eeprom_pkg::addr_t adr,
    input  eeprom_pkg::byte_t dat_w,
    input  eeprom_pkg::byte_t dat_r,
    input  logic              ack,
    input  logic              err,
    input  logic              scl,
    input  logic              sda_pull,
    input  logic              sda_pad,
    input  logic              nack_en,
    input  int                start_cnt,
    input  int                restart_cnt,
    input  int                stop_cnt,
    output int                errors
);

    eeprom_pkg::byte_t ref_mem [0:2047];
    eeprom_pkg::addr_t p_adr;
    eeprom_pkg::byte_t p_data;
    logic              pending;
    logic              p_we;
    logic              p_refuse;
    int                s0;
    int                r0;
    int                t0;
    int                exp_starts;

    initial
    begin
        errors  = 0;
        pending = 1'b0;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = i[7:0] ^ 8'h5A;
    end

    task report_mismatch(input string name, input int exp, input int act);
        $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
        errors++;
    endtask

    task report_fault(input string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endtask

    // sampled mid-cycle, away from the clock edge
    always @(negedge CLK)
    begin
        if (RESET)
        begin
            if (ack !== 1'b0)
                report_mismatch("ack", 0, int'(ack));
            if (err !== 1'b0)
                report_mismatch("err", 0, int'(err));
            if (scl !== 1'b1)
                report_mismatch("scl", 1, int'(scl));
            if (sda_pull !== 1'b0)
                report_mismatch("sda_pull", 0, int'(sda_pull));
        end
        else if (!pending)
        begin
            if (scl !== 1'b1 || sda_pad !== 1'b1)
                report_fault("two-wire bus not idle between transactions");
            if (ack || err)
                report_fault("ack or err seen without a request");
            if (cyc && stb)
            begin
                pending  = 1'b1;
                p_we     = we;
                p_adr    = adr;
                p_data   = dat_w;
                p_refuse = nack_en;
                s0       = start_cnt;
                r0       = restart_cnt;
                t0       = stop_cnt;
            end
        end
        else if (ack || err)
        begin
            pending    = 1'b0;
            exp_starts = (!p_we && !p_refuse) ? 2 : 1;
            if (err !== p_refuse)
                report_mismatch("err", int'(p_refuse), int'(err));
            if (ack && !p_we && dat_r !== ref_mem[p_adr])
                report_mismatch("dat_r", int'(ref_mem[p_adr]), int'(dat_r));
            if (ack && p_we)
                ref_mem[p_adr] = p_data;
            if (start_cnt - s0 != exp_starts)
                report_mismatch("start count", exp_starts, start_cnt - s0);
            if (restart_cnt - r0 != exp_starts - 1)
                report_mismatch("restart count", exp_starts - 1, restart_cnt - r0);
            if (stop_cnt - t0 != 1)
                report_mismatch("stop count", 1, stop_cnt - t0);
        end
    end

endmodule

// File: tb_eeprom_model.sv
`timescale 1ns/10ps

module tb_eeprom_model
(
    input  logic scl,
    input  logic sda,
    input  logic nack_en,   // refuse the control byte
    output logic pull,
    output int   start_cnt,
    output int   restart_cnt,
    output int   stop_cnt
);

    eeprom_pkg::byte_t mem [0:2047];
    eeprom_pkg::byte_t sh;
    eeprom_pkg::addr_t ptr;
    logic [2:0]        hi;
    int                bitcnt;
    int                mode;   // 0 control, 1 address, 2 data
    logic              in_frame;
    logic              active;
    logic              in_ack;
    logic              rd_next;
    logic              reading;
    logic              master_nack;
    logic              last_scl;
    logic              last_sda;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = i[7:0] ^ 8'h5A;
        pull        = 1'b0;
        start_cnt   = 0;
        restart_cnt = 0;
        stop_cnt    = 0;
        in_frame    = 1'b0;
        active      = 1'b0;
        in_ack      = 1'b0;
        rd_next     = 1'b0;
        reading     = 1'b0;
        master_nack = 1'b0;
        bitcnt      = 0;
        mode        = 0;
        ptr         = '0;
        last_scl    = 1'b1;
        last_sda    = 1'b1;
    end

    task accept_byte();
        case (mode)
            0:
            begin
                if (nack_en || sh[7:4] != 4'b1010)
                begin
                    pull   = 1'b0;
                    active = 1'b0;   // ignore the rest until stop
                end
                else
                begin
                    hi   = sh[3:1];
                    pull = 1'b1;
                    if (sh[0])
                        rd_next = 1'b1;
                    else
                        mode = 1;
                end
            end
            1:
            begin
                ptr  = {hi, sh};
                mode = 2;
                pull = 1'b1;
            end
            default:
            begin
                mem[ptr] = sh;
                ptr      = ptr + 11'd1;
                pull     = 1'b1;
            end
        endcase
    endtask

    task scl_rise();
        if (active)
        begin
            if (in_ack)
            begin
                if (reading)
                    master_nack = sda;
            end
            else
            begin
                if (!reading)
                    sh = {sh[6:0], sda};
                bitcnt++;
            end
        end
    endtask

    task scl_fall();
        if (active)
        begin
            if (in_ack)
            begin
                in_ack = 1'b0;
                pull   = 1'b0;
                bitcnt = 0;
                if (rd_next || (reading && !master_nack))
                begin
                    rd_next = 1'b0;
                    reading = 1'b1;
                    sh      = mem[ptr];
                    pull    = !sh[7];
                end
                else if (reading)
                    active = 1'b0;   // master nacked, wait for stop
            end
            else if (bitcnt == 8)
            begin
                in_ack = 1'b1;
                if (reading)
                begin
                    pull = 1'b0;
                    ptr  = ptr + 11'd1;
                end
                else
                    accept_byte();
            end
            else if (reading && bitcnt > 0)
            begin
                sh   = {sh[6:0], 1'b0};
                pull = !sh[7];
            end
        end
    endtask

    always @(scl or sda)
    begin
        if (scl && last_scl && !$isunknown(last_sda) && sda !== last_sda)
        begin
            if (!sda)
            begin
                start_cnt++;
                if (in_frame)
                    restart_cnt++;
                in_frame = 1'b1;
                active   = 1'b1;
                mode     = 0;
                bitcnt   = 0;
                in_ack   = 1'b0;
                reading  = 1'b0;
                rd_next  = 1'b0;
                pull     = 1'b0;
            end
            else
            begin
                stop_cnt++;
                in_frame = 1'b0;
                active   = 1'b0;
                reading  = 1'b0;
                pull     = 1'b0;
            end
        end
        else if (scl && !last_scl)
            scl_rise();
        else if (!scl && last_scl)
            scl_fall();
        last_scl = scl;
        last_sda = sda;
    end

endmodule

// File: eeprom_ctrl_sva.sv
`timescale 1ns/10ps

module eeprom_ctrl_sva
(
    input logic                 CLK,
    input logic                 RESET,
    input logic                 ack,
    input logic                 err,
    input logic                 cmd_valid,
    input logic                 cmd_done,
    input eeprom_pkg::bit_cmd_e cmd,
    input logic                 scl,
    input logic                 sda_pull
);

    logic in_flight;   // bit engine busy with a command

    always_ff @(posedge CLK)
    begin
        if (RESET)
            in_flight <= 1'b0;
        else if (cmd_valid)
            in_flight <= 1'b1;
        else if (cmd_done)
            in_flight <= 1'b0;
    end

    a_ack_err_excl: assert property (@(posedge CLK) disable iff (RESET) !(ack && err))
        else $error("ack and err high in the same cycle");

    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else $error("ack longer than one cycle");

    a_err_pulse: assert property (@(posedge CLK) disable iff (RESET) err |=> !err)
        else $error("err longer than one cycle");

    a_cmd_overlap: assert property (@(posedge CLK) disable iff (RESET) in_flight |-> !cmd_valid)
        else $error("new command issued before cmd_done");

    // sda may only move under a high scl for start and stop
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_pull != $past(sda_pull)))
        |-> (cmd == eeprom_pkg::cmd_start || cmd == eeprom_pkg::cmd_stop))
        else $error("sda changed while scl high outside start or stop");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_sva sva_i
(
    .CLK       (CLK),
    .RESET     (RESET),
    .ack       (ack),
    .err       (err),
    .cmd_valid (cmd_valid),
    .cmd_done  (cmd_done),
    .cmd       (cmd),
    .scl       (scl),
    .sda_pull  (sda_pull)
);

// File: eeprom_ctrl_top.sv
`timescale 1ns/10ps

module eeprom_ctrl_top
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  eeprom_pkg::addr_t adr,
    input  eeprom_pkg::byte_t dat_w,
    output eeprom_pkg::byte_t dat_r,
    output logic              ack,
    output logic              err,
    output logic              scl,
    output logic              sda_pull,   // high pulls sda low
    input  logic              sda_in
);

    logic                 req;
    logic                 req_we;
    eeprom_pkg::addr_t    req_adr;
    eeprom_pkg::byte_t    req_wdata;
    logic                 done;
    logic                 done_nack;
    eeprom_pkg::byte_t    done_rdata;
    logic                 cmd_valid;
    eeprom_pkg::bit_cmd_e cmd;
    eeprom_pkg::byte_t    cmd_byte;
    logic                 cmd_last;
    logic                 cmd_done;
    eeprom_pkg::byte_t    rx_byte;
    logic                 rx_nack;

    eeprom_wb_slave u_wb
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .err        (err),
        .req        (req),
        .req_we     (req_we),
        .req_adr    (req_adr),
        .req_wdata  (req_wdata),
        .done       (done),
        .done_nack  (done_nack),
        .done_rdata (done_rdata)
    );

    eeprom_sequencer u_seq
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .req        (req),
        .req_we     (req_we),
        .req_adr    (req_adr),
        .req_wdata  (req_wdata),
        .done       (done),
        .done_nack  (done_nack),
        .done_rdata (done_rdata),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_byte   (cmd_byte),
        .cmd_last   (cmd_last),
        .cmd_done   (cmd_done),
        .rx_byte    (rx_byte),
        .rx_nack    (rx_nack)
    );

    eeprom_bit_engine u_bit
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_byte   (cmd_byte),
        .cmd_last   (cmd_last),
        .sda_in     (sda_in),
        .cmd_done   (cmd_done),
        .rx_byte    (rx_byte),
        .rx_nack    (rx_nack),
        .scl        (scl),
        .sda_pull   (sda_pull)
    );

endmodule

// File: eeprom_bit_engine.sv
`timescale 1ns/10ps
`include "eeprom_config.svh"

module eeprom_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::bit_cmd_e cmd,
    input  eeprom_pkg::byte_t    cmd_byte,
    input  logic                 cmd_last,
    input  logic                 sda_in,
    output logic                 cmd_done,
    output eeprom_pkg::byte_t    rx_byte,
    output logic                 rx_nack,
    output logic                 scl,
    output logic                 sda_pull
);

    localparam int QW = $clog2(`EEPROM_SCL_QUARTER + 1);
    localparam logic [QW-1:0] QLAST = QW'(`EEPROM_SCL_QUARTER - 1);

    eeprom_pkg::bit_state_e state;
    eeprom_pkg::byte_t      shreg;
    logic [QW-1:0]          qcnt;
    logic [1:0]             phase;
    logic [2:0]             bitcnt;
    logic                   rd_q;
    logic                   last_q;
    logic                   samp;
    logic                   tick;
    logic                   scl_d;
    logic                   pull_d;

    assign tick    = (qcnt == QLAST);
    assign rx_byte = shreg;

    // phases 0 and 3 scl low, 1 and 2 scl high
    always_comb
    begin
        scl_d  = scl;
        pull_d = sda_pull;
        case (state)
            eeprom_pkg::bit_start:
            begin
                scl_d  = (phase == 2'd1) || (phase == 2'd2);
                pull_d = phase[1];   // sda falls in phase 2
            end
            eeprom_pkg::bit_stop:
            begin
                scl_d  = (phase != 2'd0);   // left high, bus idle
                pull_d = !phase[1];
            end
            eeprom_pkg::bit_shift:
            begin
                scl_d  = (phase == 2'd1) || (phase == 2'd2);
                pull_d = !rd_q && !shreg[7];
            end
            eeprom_pkg::bit_ack:
            begin
                scl_d  = (phase == 2'd1) || (phase == 2'd2);
                pull_d = rd_q && !last_q;   // master ack unless last
            end
            default:
            begin
                scl_d  = scl;
                pull_d = sda_pull;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= eeprom_pkg::bit_idle;
            qcnt     <= '0;
            phase    <= 2'd0;
            bitcnt   <= 3'd0;
            rd_q     <= 1'b0;
            last_q   <= 1'b0;
            cmd_done <= 1'b0;
            rx_nack  <= 1'b0;
            scl      <= 1'b1;
            sda_pull <= 1'b0;
        end
        else
        begin
            scl      <= scl_d;
            sda_pull <= pull_d;
            cmd_done <= 1'b0;
            if (state == eeprom_pkg::bit_idle)
            begin
                qcnt   <= '0;
                phase  <= 2'd0;
                bitcnt <= 3'd0;
                if (cmd_valid)
                begin
                    rd_q   <= (cmd == eeprom_pkg::cmd_read);
                    last_q <= cmd_last;
                    case (cmd)
                        eeprom_pkg::cmd_start: state <= eeprom_pkg::bit_start;
                        eeprom_pkg::cmd_stop:  state <= eeprom_pkg::bit_stop;
                        default:               state <= eeprom_pkg::bit_shift;
                    endcase
                end
            end
            else
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                begin
                    phase <= phase + 2'd1;
                    if (state == eeprom_pkg::bit_ack && phase == 2'd1)
                        rx_nack <= rd_q ? 1'b0 : sda_in;
                    if (phase == 2'd3)
                    begin
                        bitcnt <= bitcnt + 3'd1;
                        if (state != eeprom_pkg::bit_shift)
                        begin
                            state    <= eeprom_pkg::bit_idle;
                            cmd_done <= 1'b1;
                        end
                        else if (bitcnt == 3'd7)
                            state <= eeprom_pkg::bit_ack;
                    end
                end
            end
        end
    end

    // shared shifter, writes push out MSB first, reads pull in the sample
    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::bit_idle && cmd_valid)
            shreg <= cmd_byte;
        else if (state == eeprom_pkg::bit_shift && tick)
        begin
            if (phase == 2'd1)
                samp <= sda_in;   // middle of scl high
            if (phase == 2'd3)
                shreg <= {shreg[6:0], samp};
        end
    end

endmodule

// File: eeprom_sequencer.sv
`timescale 1ns/10ps
`include "eeprom_config.svh"

module eeprom_sequencer
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 req,
    input  logic                 req_we,
    input  eeprom_pkg::addr_t    req_adr,
    input  eeprom_pkg::byte_t    req_wdata,
    output logic                 done,
    output logic                 done_nack,
    output eeprom_pkg::byte_t    done_rdata,
    output logic                 cmd_valid,
    output eeprom_pkg::bit_cmd_e cmd,
    output eeprom_pkg::byte_t    cmd_byte,
    output logic                 cmd_last,
    input  logic                 cmd_done,
    input  eeprom_pkg::byte_t    rx_byte,
    input  logic                 rx_nack
);

    eeprom_pkg::seq_state_e state;
    eeprom_pkg::seq_state_e nxt;
    eeprom_pkg::bit_cmd_e   cmd_d;
    eeprom_pkg::byte_t      byte_d;
    logic                   issue;
    logic                   wr_byte;

    // states whose byte the slave has to acknowledge
    assign wr_byte = (state == eeprom_pkg::seq_ctrl_wr) || (state == eeprom_pkg::seq_addr) ||
                     (state == eeprom_pkg::seq_data_wr) || (state == eeprom_pkg::seq_ctrl_rd);

    always_comb
    begin
        nxt = state;
        case (state)
            eeprom_pkg::seq_idle:
                if (req)
                    nxt = eeprom_pkg::seq_start;
            eeprom_pkg::seq_start:
                if (cmd_done)
                    nxt = eeprom_pkg::seq_ctrl_wr;
            eeprom_pkg::seq_ctrl_wr:
                if (cmd_done)
                    nxt = rx_nack ? eeprom_pkg::seq_stop : eeprom_pkg::seq_addr;
            eeprom_pkg::seq_addr:
            begin
                if (cmd_done && rx_nack)
                    nxt = eeprom_pkg::seq_stop;
                else if (cmd_done)
                    nxt = req_we ? eeprom_pkg::seq_data_wr : eeprom_pkg::seq_restart;
            end
            eeprom_pkg::seq_data_wr:
                if (cmd_done)
                    nxt = eeprom_pkg::seq_stop;
            eeprom_pkg::seq_restart:
                if (cmd_done)
                    nxt = eeprom_pkg::seq_ctrl_rd;
            eeprom_pkg::seq_ctrl_rd:
                if (cmd_done)
                    nxt = rx_nack ? eeprom_pkg::seq_stop : eeprom_pkg::seq_data_rd;
            eeprom_pkg::seq_data_rd:
                if (cmd_done)
                    nxt = eeprom_pkg::seq_stop;
            eeprom_pkg::seq_stop:
                if (cmd_done)
                    nxt = eeprom_pkg::seq_finish;
            default:
                nxt = eeprom_pkg::seq_idle;
        endcase
    end

    // command belonging to the state being entered
    always_comb
    begin
        cmd_d  = eeprom_pkg::cmd_write;
        byte_d = req_wdata;
        issue  = (nxt != state);
        case (nxt)
            eeprom_pkg::seq_start,
            eeprom_pkg::seq_restart:
                cmd_d = eeprom_pkg::cmd_start;
            eeprom_pkg::seq_ctrl_wr:
                byte_d = {`EEPROM_DEV_CODE, req_adr[10:8], 1'b0};
            eeprom_pkg::seq_addr:
                byte_d = req_adr[7:0];
            eeprom_pkg::seq_ctrl_rd:
                byte_d = {`EEPROM_DEV_CODE, req_adr[10:8], 1'b1};
            eeprom_pkg::seq_data_rd:
                cmd_d = eeprom_pkg::cmd_read;
            eeprom_pkg::seq_stop:
                cmd_d = eeprom_pkg::cmd_stop;
            eeprom_pkg::seq_data_wr:
                byte_d = req_wdata;
            default:
                issue = 1'b0;   // idle and finish drive nothing
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::seq_idle;
            cmd_valid <= 1'b0;
            done      <= 1'b0;
            done_nack <= 1'b0;
        end
        else
        begin
            state     <= nxt;
            cmd_valid <= issue;
            done      <= (state == eeprom_pkg::seq_finish);
            if (state == eeprom_pkg::seq_idle && req)
                done_nack <= 1'b0;
            else if (cmd_done && wr_byte && rx_nack)
                done_nack <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (issue)
        begin
            cmd      <= cmd_d;
            cmd_byte <= byte_d;
            cmd_last <= (nxt == eeprom_pkg::seq_data_rd);   // single byte read, always last
        end
        if (state == eeprom_pkg::seq_data_rd && cmd_done)
            done_rdata <= rx_byte;
    end

endmodule

// File: eeprom_wb_slave.sv
`timescale 1ns/10ps

module eeprom_wb_slave
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  eeprom_pkg::addr_t adr,
    input  eeprom_pkg::byte_t dat_w,
    output eeprom_pkg::byte_t dat_r,
    output logic              ack,
    output logic              err,
    output logic              req,
    output logic              req_we,
    output eeprom_pkg::addr_t req_adr,
    output eeprom_pkg::byte_t req_wdata,
    input  logic              done,
    input  logic              done_nack,
    input  eeprom_pkg::byte_t done_rdata
);

    logic busy;
    logic capture;

    // ack/err cycle still shows stb high, so skip it
    assign capture = cyc && stb && !busy && !ack && !err;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy <= 1'b0;
            req  <= 1'b0;
            ack  <= 1'b0;
            err  <= 1'b0;
        end
        else
        begin
            req <= 1'b0;
            ack <= 1'b0;
            err <= 1'b0;
            if (capture)
            begin
                busy <= 1'b1;
                req  <= 1'b1;
            end
            else if (busy && done)
            begin
                busy <= 1'b0;
                ack  <= !done_nack;
                err  <= done_nack;   // device refused a byte
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (capture)
        begin
            req_we    <= we;
            req_adr   <= adr;
            req_wdata <= dat_w;
        end
        if (busy && done && !req_we)
            dat_r <= done_rdata;
    end

endmodule

// File: eeprom_pkg.sv
`include "eeprom_config.svh"

package eeprom_pkg;

    typedef logic [`EEPROM_ADDR_W-1:0] addr_t;
    typedef logic [`EEPROM_DATA_W-1:0] byte_t;

    typedef enum logic [1:0]
    {
        cmd_start,
        cmd_stop,
        cmd_write,
        cmd_read
    } bit_cmd_e;

    // frame sequence of one transaction
    typedef enum logic [3:0]
    {
        seq_idle,
        seq_start,
        seq_ctrl_wr,
        seq_addr,
        seq_data_wr,
        seq_restart,
        seq_ctrl_rd,
        seq_data_rd,
        seq_stop,
        seq_finish
    } seq_state_e;

    typedef enum logic [2:0]
    {
        bit_idle,
        bit_start,
        bit_stop,
        bit_shift,
        bit_ack        // ninth bit of a byte
    } bit_state_e;

endpackage

// File: eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// 24C16 style part, 2 Kbyte
`define EEPROM_ADDR_W 11
`define EEPROM_DATA_W 8

// CLK cycles per quarter of an scl period
`define EEPROM_SCL_QUARTER 4

// device type code in the upper nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

`endif
